// ==== rr_dispatch.f ====
source/dispatch_pkg.sv
source/arb_if.sv
source/rr_arb20.sv
source/channel_store.sv
source/dispatch_ctrl.sv
source/dispatch_out.sv
source/rr_dispatch_top.sv
verification/dispatch_checker.sv
verification/tb_rr_dispatch.sv

// ==== verification/tb_rr_dispatch.sv ====
`timescale 1ns/10ps

module tb_rr_dispatch;
	import dispatch_pkg::*;

	// Test, run, in_valid, in_chan, in_data, idle cycles after.
	typedef struct packed {
		logic [3:0] test;
		logic run;
		logic valid;
		logic [4:0] chan;
		logic [15:0] data;
		logic [7:0] idle;
	} row_t;

	localparam int NUM_ROWS = 17;

	logic clk;
	logic reset;
	logic run;
	logic in_valid;
	chan_idx_t in_chan;
	word_t in_data;
	logic out_valid;
	chan_idx_t out_chan;
	word_t out_data;
	count_t drop_count;
	count_t dispatch_count;

	integer seed;       // Random word source.
	int errors_before;  // Checker errors at the start of a test.
	int tests_done;     // Tests reported so far.
	logic last_row;     // Row closes its test.
	logic timed_out;    // Output wait gave up.
	row_t stim [NUM_ROWS];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus table.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		stim[0] = {4'd1, 1'b0, 1'b0, 5'd0, 16'h0000, 8'd2};   // Idle after reset.
		stim[1] = {4'd2, 1'b1, 1'b1, 5'd7, 16'h0000, 8'd0};   // Lone word on 7.
		stim[2] = {4'd3, 1'b1, 1'b1, 5'd0, 16'h0000, 8'd8};   // Park pointer on 0.
		stim[3] = {4'd3, 1'b0, 1'b1, 5'd0, 16'h0000, 8'd0};
		stim[4] = {4'd3, 1'b0, 1'b1, 5'd3, 16'h0000, 8'd0};
		stim[5] = {4'd3, 1'b0, 1'b1, 5'd12, 16'h0000, 8'd0};
		stim[6] = {4'd3, 1'b0, 1'b1, 5'd19, 16'h0000, 8'd2};
		stim[7] = {4'd3, 1'b1, 1'b0, 5'd0, 16'h0000, 8'd0};   // Let them go.
		stim[8] = {4'd4, 1'b0, 1'b1, 5'd5, 16'h1111, 8'd0};   // Original word.
		stim[9] = {4'd4, 1'b0, 1'b1, 5'd5, 16'h2222, 8'd0};   // Must drop.
		stim[10] = {4'd4, 1'b1, 1'b0, 5'd0, 16'h0000, 8'd0};
		stim[11] = {4'd5, 1'b0, 1'b1, 5'd2, 16'h0000, 8'd0};
		stim[12] = {4'd5, 1'b0, 1'b1, 5'd9, 16'h0000, 8'd0};
		stim[13] = {4'd5, 1'b0, 1'b1, 5'd14, 16'h0000, 8'd0};
		stim[14] = {4'd5, 1'b0, 1'b1, 5'd17, 16'h0000, 8'd6}; // Held with run low.
		stim[15] = {4'd5, 1'b1, 1'b0, 5'd0, 16'h0000, 8'd0};
		stim[16] = {4'd6, 1'b1, 1'b0, 5'd0, 16'h0000, 8'd2};  // Final totals.
	end

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	rr_dispatch_top dut (
		.clk(clk),
		.reset(reset),
		.run(run),
		.in_valid(in_valid),
		.in_chan(in_chan),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_chan(out_chan),
		.out_data(out_data),
		.drop_count(drop_count),
		.dispatch_count(dispatch_count)
	);

	dispatch_checker chk (
		.clk(clk),
		.reset(reset),
		.run(run),
		.in_valid(in_valid),
		.in_chan(in_chan),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_chan(out_chan),
		.out_data(out_data),
		.drop_count(drop_count),
		.dispatch_count(dispatch_count)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tasks enter and leave 10 ns after a rising edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apply_row(input row_t r);
		run = r.run;
		in_valid = r.valid;
		in_chan = r.chan;
		if (r.test == 4'd4) begin
			in_data = r.data; // Fixed words to tell old from new.
		end else begin
			in_data = word_t'($random(seed));
		end
		@(posedge clk);
		#10;
		in_valid = 1'b0; // Write strobe is one cycle.
		repeat (r.idle) begin
			@(posedge clk);
			#10;
		end
	endtask

	// Waits until the DUT has sent every accepted word or stays quiet for 50 cycles.
	task automatic wait_drained(input int test_no, output logic gave_up);
		int quiet;
		int last_pulses;
		quiet = 0;
		last_pulses = chk.pulses;
		gave_up = 1'b0;
		while (chk.pulses < chk.accepted && !gave_up) begin
			@(posedge clk);
			#10;
			if (chk.pulses != last_pulses) begin
				last_pulses = chk.pulses;
				quiet = 0;
			end else begin
				quiet++;
			end
			if (quiet >= 50) begin
				$display("test %0d: no output for 50 cycles with words waiting", test_no);
				gave_up = 1'b1;
			end
		end
	endtask

	task automatic report_test(input int test_no);
		int n;
		n = chk.errors - errors_before;
		if (n == 0 && !timed_out) begin
			$display("test %0d: pass", test_no);
		end else begin
			$display("test %0d: fail, %0d mismatches", test_no, n);
		end
		errors_before = chk.errors;
		tests_done++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		seed = 32'h2b0f0486;
		reset = 1'b1;
		run = 1'b0;
		in_valid = 1'b0;
		in_chan = '0;
		in_data = '0;
		errors_before = 0;
		tests_done = 0;
		timed_out = 1'b0;
		repeat (8) @(posedge clk);
		#10;
		reset = 1'b0;
		for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
			apply_row(stim[i]);
			last_row = (i == NUM_ROWS - 1);
			if (!last_row) begin
				last_row = (stim[i + 1].test != stim[i].test);
			end
			if (last_row) begin
				if (stim[i].run) begin
					wait_drained(stim[i].test, timed_out);
				end
				if (stim[i].test == 4'd3) begin
					chk.check_order(3, 12, 19, 0); // Strictly after pointer 0.
				end
				if (stim[i].test == 4'd6) begin
					chk.check_final();
				end
				report_test(stim[i].test);
			end
		end
		$display("tests %0d, checks %0d, failed checks %0d", tests_done, chk.checks, chk.errors);
		if (chk.errors == 0 && !timed_out) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== verification/dispatch_checker.sv ====
`timescale 1ns/10ps

module dispatch_checker (
	input logic clk,
	input logic reset,
	input logic run,
	input logic in_valid,
	input dispatch_pkg::chan_idx_t in_chan,
	input dispatch_pkg::word_t in_data,
	input logic out_valid,
	input dispatch_pkg::chan_idx_t out_chan,
	input dispatch_pkg::word_t out_data,
	input dispatch_pkg::count_t drop_count,
	input dispatch_pkg::count_t dispatch_count
);
	import dispatch_pkg::*;

	word_t m_data [NUM_CHANNELS]; // Model slot words.
	chan_mask_t m_valid;          // Model slot full bits.
	chan_mask_t req_pre;          // Full bits seen at the edge.
	int m_ptr;                    // Model arbiter pointer.
	logic m_grant_state;          // Model FSM, high in the grant cycle.
	logic m_gnt;                  // Model registered grant.
	logic m_en;                   // Arbiter enable this cycle.
	logic m_pop;                  // Pop this cycle.
	logic exp_valid;              // Expected output strobe.
	chan_idx_t exp_chan;          // Expected output channel.
	word_t exp_data;              // Expected output word.
	int exp_drops;                // Expected drop_count.
	int exp_sent;                 // Expected dispatch_count.
	int accepted;                 // Words that landed in a slot.
	int pulses;                   // out_valid pulses seen.
	int checks;                   // Comparisons made.
	int errors;                   // Comparisons failed.
	int seen [$];                 // Channels in output order.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// First requester strictly after p, walking upward with wrap.
	function automatic int next_after(input int p, input chan_mask_t req);
		int hit;
		hit = p; // Nobody else asks, pointer stays.
		for (int k = NUM_CHANNELS - 1; k >= 1; k--) begin
			if (req[(p + k) % NUM_CHANNELS]) begin
				hit = (p + k) % NUM_CHANNELS; // Nearer one wins.
			end
		end
		return hit;
	endfunction

	task automatic compare(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		checks++;
		if (exp_v !== act_v) begin
			errors++;
			$display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
		end
	endtask

	// Last four channels out must follow the given order.
	task automatic check_order(input int c0, input int c1, input int c2, input int c3);
		int base;
		base = seen.size() - 4;
		if (base < 0) begin
			errors++;
			$display("order check: fewer than four words came out");
			return;
		end
		compare("out_chan order 0", c0, seen[base]);
		compare("out_chan order 1", c1, seen[base + 1]);
		compare("out_chan order 2", c2, seen[base + 2]);
		compare("out_chan order 3", c3, seen[base + 3]);
	endtask

	task automatic check_final();
		compare("dispatch_count vs pulses", pulses, dispatch_count);
		compare("words delivered vs accepted", accepted, pulses);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model, steps once per rising edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		if (reset) begin
			m_valid = '0;
			m_ptr = 0;
			m_grant_state = 1'b0;
			m_gnt = 1'b0;
			exp_valid = 1'b0;
			exp_drops = 0;
			exp_sent = 0;
		end else begin
			req_pre = m_valid;                 // Requests before this edge.
			m_en = !m_grant_state && run;      // Issue cycle with run.
			m_pop = m_grant_state && m_gnt;    // Grant cycle after a hit.
			exp_valid = m_pop;
			if (m_pop) begin
				exp_chan = chan_idx_t'(m_ptr);
				exp_data = m_data[m_ptr];
				m_valid[m_ptr] = 1'b0;
				exp_sent++;
			end
			if (in_valid) begin
				if (in_chan < NUM_CHANNELS && !req_pre[in_chan]) begin
					m_data[in_chan] = in_data; // Empty slot at the edge.
					m_valid[in_chan] = 1'b1;
					accepted++;
				end else begin
					exp_drops++; // Full, or popped at this edge.
				end
			end
			m_gnt = m_en && (|req_pre);
			if (m_en) begin
				m_ptr = next_after(m_ptr, req_pre);
			end
			m_grant_state = m_en; // Grant follows every issue.
		end
	end

	// Outputs compared mid-cycle, clear of the edge.
	always @(negedge clk) begin
		if (!reset) begin
			compare("out_valid", exp_valid, out_valid);
			if (out_valid) begin
				pulses++;
				seen.push_back(int'(out_chan));
			end
			if (exp_valid && out_valid) begin
				compare("out_chan", exp_chan, out_chan);
				compare("out_data", exp_data, out_data);
			end
			compare("drop_count", exp_drops, drop_count);
			compare("dispatch_count", exp_sent, dispatch_count);
		end
	end

endmodule

// ==== source/rr_dispatch_top.sv ====
`timescale 1ns/10ps

module rr_dispatch_top (
	input logic clk,
	input logic reset,
	input logic run,
	input logic in_valid,
	input dispatch_pkg::chan_idx_t in_chan,
	input dispatch_pkg::word_t in_data,
	output logic out_valid,
	output dispatch_pkg::chan_idx_t out_chan,
	output dispatch_pkg::word_t out_data,
	output dispatch_pkg::count_t drop_count,
	output dispatch_pkg::count_t dispatch_count
);
	import dispatch_pkg::*;

	logic pop;      // Granted slot leaves this cycle.
	word_t rd_data; // Slot at the arbiter pointer.

	arb_if arb_bus (.clk(clk)); // Store, arbiter and control.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instances.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	rr_arb20 u_arb (
		.clk(clk),
		.reset(reset),
		.arb(arb_bus.arbiter)
	);

	channel_store u_store (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_chan(in_chan),
		.in_data(in_data),
		.pop(pop),
		.arb(arb_bus.store),
		.rd_data(rd_data),
		.drop_count(drop_count)
	);

	dispatch_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.run(run),
		.arb(arb_bus.ctrl),
		.pop(pop)
	);

	dispatch_out u_out (
		.clk(clk),
		.reset(reset),
		.pop(pop),
		.sel(arb_bus.sel), // Same pointer the store reads with.
		.rd_data(rd_data),
		.out_valid(out_valid),
		.out_chan(out_chan),
		.out_data(out_data),
		.dispatch_count(dispatch_count)
	);

endmodule

// ==== source/dispatch_out.sv ====
`timescale 1ns/10ps

module dispatch_out (
	input logic clk,
	input logic reset,
	input logic pop,
	input dispatch_pkg::chan_idx_t sel,
	input dispatch_pkg::word_t rd_data,
	output logic out_valid,
	output dispatch_pkg::chan_idx_t out_chan,
	output dispatch_pkg::word_t out_data,
	output dispatch_pkg::count_t dispatch_count
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output strobe and payload.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= pop; // One cycle, no back-pressure.
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			out_chan <= sel;      // Pointer names the channel.
			out_data <= rd_data;  // Slot contents before the clear.
		end
	end

	// Words handed out since reset.
	always_ff @(posedge clk) begin
		if (reset) begin
			dispatch_count <= '0;
		end else if (pop) begin
			dispatch_count <= dispatch_count + 1'b1;
		end
	end

endmodule

// ==== source/dispatch_ctrl.sv ====
`timescale 1ns/10ps

module dispatch_ctrl (
	input logic clk,
	input logic reset,
	input logic run,
	arb_if.ctrl arb,
	output logic pop
);
	import dispatch_pkg::*;

	ctrl_state_t state;      // Current state.
	ctrl_state_t state_next; // State after this edge.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State register and next state.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ISSUE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ISSUE: begin
				if (run) begin
					state_next = GRANT; // Arbiter moves at this edge.
				end
			end
			GRANT: begin
				state_next = ISSUE; // Always one cycle, run or not.
			end
			default: begin
				state_next = ISSUE;
			end
		endcase
	end

	// Outputs decode the state directly.
	assign arb.en = (state == ISSUE) && run;  // One-cycle request.
	assign pop = (state == GRANT) && arb.gnt; // Only if a slot was full.

	// Pointer must hold steady across the edge that ends GRANT.
	a_no_en_in_grant: assert property (@(posedge clk) disable iff (reset)
		(state == GRANT) |=> $stable(arb.sel))
		else $error("dispatch_ctrl: pointer moved after GRANT");

endmodule

// ==== source/channel_store.sv ====
`timescale 1ns/10ps

module channel_store (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input dispatch_pkg::chan_idx_t in_chan,
	input dispatch_pkg::word_t in_data,
	input logic pop,
	arb_if.store arb,
	output dispatch_pkg::word_t rd_data,
	output dispatch_pkg::count_t drop_count
);
	import dispatch_pkg::*;

	word_t slot_mem [NUM_CHANNELS]; // One word per channel.
	chan_mask_t slot_valid;         // Slot holds a word.
	logic chan_ok;                  // Channel number is in range.
	logic wr_accept;                // Write lands in an empty slot.
	logic wr_drop;                  // Write is thrown away.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign chan_ok = in_chan < NUM_CHANNELS;
	// A slot being popped is still valid here, so that write drops too.
	assign wr_accept = in_valid && chan_ok && !slot_valid[in_chan];
	assign wr_drop = in_valid && !wr_accept;

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			slot_mem[in_chan] <= in_data; // Payload only, no reset.
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= '0;
		end else begin
			if (pop) begin
				slot_valid[arb.sel] <= 1'b0; // Granted word leaves.
			end
			if (wr_accept) begin
				slot_valid[in_chan] <= 1'b1; // Never the popped slot.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			drop_count <= '0;
		end else if (wr_drop) begin
			drop_count <= drop_count + 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign arb.req = slot_valid;        // Full slots ask for service.
	assign rd_data = slot_mem[arb.sel]; // Word under the pointer.

	// The arbiter only grants a full slot, so a pop never hits an empty one.
	a_pop_valid: assert property (@(posedge clk) disable iff (reset)
		pop |-> slot_valid[arb.sel])
		else $error("channel_store: pop of empty slot %0d", arb.sel);

endmodule

// ==== source/rr_arb20.sv ====
`timescale 1ns/10ps

module rr_arb20 (
	input logic clk,
	input logic reset,
	arb_if.arbiter arb
);
	import dispatch_pkg::*;

	chan_idx_t ptr;                 // Round-robin pointer.
	chan_mask_t rot_req;            // Requests seen from the pointer.
	chan_idx_t pri_off;             // Distance to the next requester.
	logic [CHAN_IDX_W:0] ptr_sum;   // Pointer plus offset, one spare bit.
	logic [CHAN_IDX_W:0] ptr_wrap;  // Same, less one full turn.
	chan_idx_t next_ptr;            // Pointer after this cycle.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Rotate right by cnt, so bit i is request (i + cnt) mod 20.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic chan_mask_t rot20(input chan_mask_t din, input chan_idx_t cnt);
		chan_mask_t s16;
		chan_mask_t s8;
		chan_mask_t s4;
		chan_mask_t s2;
		s16 = cnt[4] ? {din[15:0], din[19:16]} : din; // By 16.
		s8 = cnt[3] ? {s16[7:0], s16[19:8]} : s16;     // By 8.
		s4 = cnt[2] ? {s8[3:0], s8[19:4]} : s8;        // By 4.
		s2 = cnt[1] ? {s4[1:0], s4[19:2]} : s4;        // By 2.
		return cnt[0] ? {s2[0], s2[19:1]} : s2;        // By 1.
	endfunction

	// Lowest set bit from index 1 up; bit 0 is the pointer itself.
	function automatic chan_idx_t pri20(input chan_mask_t din);
		chan_idx_t off;
		off = '0; // Nothing else asks, stay put.
		for (int i = NUM_CHANNELS - 1; i >= 1; i--) begin
			if (din[i]) begin
				off = chan_idx_t'(i); // Lower index overrides.
			end
		end
		return off;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next pointer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign rot_req = rot20(arb.req, ptr);
	assign pri_off = pri20(rot_req);

	always_comb begin
		ptr_sum = {1'b0, ptr} + {1'b0, pri_off};                // At most 19 + 19.
		ptr_wrap = ptr_sum - (CHAN_IDX_W + 1)'(NUM_CHANNELS); // Modulo 20.
		if (ptr_sum >= (CHAN_IDX_W + 1)'(NUM_CHANNELS)) begin
			next_ptr = ptr_wrap[CHAN_IDX_W-1:0];
		end else begin
			next_ptr = ptr_sum[CHAN_IDX_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
			arb.gnt <= 1'b0;
		end else begin
			if (arb.en) begin
				ptr <= next_ptr; // Move only when asked.
			end
			arb.gnt <= arb.en & (|arb.req); // Grant valid in the next cycle.
		end
	end

	assign arb.sel = ptr; // Pointer doubles as the select.

	// Slot index stays in range across every wrap.
	a_sel_range: assert property (@(posedge clk) disable iff (reset)
		arb.sel < NUM_CHANNELS)
		else $error("rr_arb20: sel %0d out of range", arb.sel);

endmodule

// ==== source/arb_if.sv ====
`timescale 1ns/10ps

interface arb_if (
	input logic clk
);
	import dispatch_pkg::*;

	chan_mask_t req; // Full slots, from the store.
	logic en;        // Advance the arbiter this cycle.
	chan_idx_t sel;  // Current arbiter pointer.
	logic gnt;       // Registered, en and any req.

	modport arbiter (input req, input en, output sel, output gnt);
	modport store (output req, input sel);
	modport ctrl (output en, input gnt, input sel);

	// Issue and grant cycles alternate, so en and gnt never overlap.
	a_en_gnt_apart: assert property (@(posedge clk) !(en === 1'b1 && gnt === 1'b1))
		else $error("arb_if: en and gnt high in the same cycle");

endinterface

// ==== source/dispatch_pkg.sv ====
package dispatch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sizes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int NUM_CHANNELS = 20; // Channels served by the arbiter.
	localparam int CHAN_IDX_W = 5;    // Enough for 0..19.
	localparam int DATA_W = 16;       // Payload word.
	localparam int COUNT_W = 16;      // Drop and dispatch counters.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [CHAN_IDX_W-1:0] chan_idx_t;    // Channel number.
	typedef logic [NUM_CHANNELS-1:0] chan_mask_t; // One bit per channel.
	typedef logic [DATA_W-1:0] word_t;            // Data word.
	typedef logic [COUNT_W-1:0] count_t;          // Event counter, wraps.

	// Control FSM, one issue cycle then one grant cycle.
	typedef enum logic {
		ISSUE = 1'b0, // Ask the arbiter for the next channel.
		GRANT = 1'b1  // Pop the granted slot if gnt came back.
	} ctrl_state_t;

endpackage
